/* common/saPkg.sv */
package saPkg;

   // Operand and accumulator widths
   localparam int DataWidth = 8;
   localparam int AccWidth  = 24;   // Headroom for long jobs

   // Radix-4 recoding handles two multiplier bits per digit
   localparam int BoothDigits = DataWidth / 2;

   // Array size used when the top level is not overridden
   localparam int DefaultRows = 4;
   localparam int DefaultCols = 4;

   // One A or B element
   typedef logic signed [DataWidth-1:0] operandT;

   // Full-precision Booth product
   typedef logic signed [2*DataWidth-1:0] productT;

   // Running sum and result element
   typedef logic signed [AccWidth-1:0] accT;

   // Operand moving between neighbours with its beat flags
   typedef struct packed {
      logic    valid;
      logic    last;    // Final beat of the job
      operandT value;
   } peLinkT;

endpackage

/* design/boothMultiplier.sv */
`timescale 1ns/1ps

module boothMultiplier (
   input  saPkg::operandT multiplicand,
   input  saPkg::operandT multiplier,
   output saPkg::productT product
);

   // Partial products carry one extra bit so that twice the multiplicand fits
   localparam int PpWidth = saPkg::DataWidth + 1;

   logic [saPkg::DataWidth:0] recoded;
   logic signed [PpWidth-1:0] extended;
   logic [saPkg::BoothDigits-1:0] selOne;
   logic [saPkg::BoothDigits-1:0] selTwo;
   logic [saPkg::BoothDigits-1:0] negate;
   logic signed [PpWidth-1:0] partial [saPkg::BoothDigits];

   assign recoded  = {multiplier, 1'b0};   // Implicit zero below the LSB
   assign extended = {multiplicand[saPkg::DataWidth-1], multiplicand};

   for (genvar k = 0; k < saPkg::BoothDigits; k++) begin : gDigit
      logic [2:0] triplet;
      logic [PpWidth-1:0] picked;

      assign triplet = recoded[2*k+2 -: 3];

      // Encoder
      assign selOne[k] = triplet[0] ^ triplet[1];
      assign selTwo[k] = (triplet[1] ^ triplet[2]) & ~(triplet[0] ^ triplet[1]);
      assign negate[k] = triplet[2];

      // Selector, 000 and 111 pick zero
      assign picked = ({PpWidth{selOne[k]}} & extended)
                    | ({PpWidth{selTwo[k]}} & {extended[PpWidth-2:0], 1'b0});

      // Ones complement here, the +1 is folded into the sum below
      assign partial[k] = picked ^ {PpWidth{negate[k]}};
   end

   // Sign-extended partial products weighted by 4^k
   always_comb begin
      product = '0;
      for (int k = 0; k < saPkg::BoothDigits; k++) begin
         product = product + (saPkg::productT'(partial[k]) <<< (2 * k));
         product = product + (saPkg::productT'(negate[k]) << (2 * k));
      end
   end

endmodule

/* peArray/processingElement.sv */
`timescale 1ns/1ps

module processingElement (
   input  logic          clk,
   input  logic          reset,
   input  logic          advance,
   input  saPkg::peLinkT west,
   input  saPkg::peLinkT north,
   output saPkg::peLinkT east,
   output saPkg::peLinkT south,
   output logic          doneValid,
   output saPkg::accT    doneSum
);

   saPkg::productT product;
   saPkg::accT     acc;
   saPkg::accT     accNext;
   logic           fire;
   logic           eastValid;
   logic           eastLast;
   logic           southValid;
   logic           southLast;
   saPkg::operandT eastValue;
   saPkg::operandT southValue;

   boothMultiplier uMul (
      .multiplicand(west.value),
      .multiplier  (north.value),
      .product     (product)
   );

   assign fire    = advance && west.valid;
   assign accNext = acc + saPkg::accT'(product);

   always_ff @(posedge clk) begin
      if (reset) begin
         acc        <= '0;
         doneValid  <= 1'b0;
         eastValid  <= 1'b0;
         eastLast   <= 1'b0;
         southValid <= 1'b0;
         southLast  <= 1'b0;
      end else if (advance) begin
         eastValid  <= west.valid;
         eastLast   <= west.last;
         southValid <= north.valid;
         southLast  <= north.last;
         doneValid  <= west.valid && west.last;
         if (west.valid) begin
            acc <= west.last ? '0 : accNext;   // Next job starts from zero
         end
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         eastValue  <= west.value;
         southValue <= north.value;
      end
      if (fire && west.last) doneSum <= accNext;
   end

   assign east  = '{valid: eastValid, last: eastLast, value: eastValue};
   assign south = '{valid: southValid, last: southLast, value: southValue};

   // The skew must bring A and B of the same beat here together
   assert property (@(posedge clk) disable iff (reset)
      (west.valid == north.valid) && (!west.valid || (west.last == north.last)));

endmodule

/* peArray/peGrid.sv */
`timescale 1ns/1ps

module peGrid #(
   parameter int Rows = saPkg::DefaultRows,
   parameter int Cols = saPkg::DefaultCols
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                advance,
   input  saPkg::peLinkT [Rows-1:0]            westIn,
   input  saPkg::peLinkT [Cols-1:0]            northIn,
   output logic [Rows-1:0][Cols-1:0]           doneValid,
   output saPkg::accT [Rows-1:0][Cols-1:0]     doneSum
);

   // Column Cols and row Rows are the links leaving the far edges
   saPkg::peLinkT eastLink  [Rows][Cols+1];
   saPkg::peLinkT southLink [Rows+1][Cols];

   for (genvar i = 0; i < Rows; i++) begin : gWestEdge
      assign eastLink[i][0] = westIn[i];
   end

   for (genvar j = 0; j < Cols; j++) begin : gNorthEdge
      assign southLink[0][j] = northIn[j];
   end

   for (genvar i = 0; i < Rows; i++) begin : gRow
      for (genvar j = 0; j < Cols; j++) begin : gCol
         processingElement uPe (
            .clk      (clk),
            .reset    (reset),
            .advance  (advance),
            .west     (eastLink[i][j]),
            .north    (southLink[i][j]),
            .east     (eastLink[i][j+1]),
            .south    (southLink[i+1][j]),
            .doneValid(doneValid[i][j]),
            .doneSum  (doneSum[i][j])
         );
      end
   end

endmodule

/* design/operandSkew.sv */
`timescale 1ns/1ps

module operandSkew #(
   parameter int Rows = saPkg::DefaultRows,
   parameter int Cols = saPkg::DefaultCols
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       advance,
   input  logic                       take,
   input  logic                       takeLast,
   input  saPkg::operandT [Rows-1:0]  aCol,
   input  saPkg::operandT [Cols-1:0]  bRow,
   output saPkg::peLinkT [Rows-1:0]   westOut,
   output saPkg::peLinkT [Cols-1:0]   northOut
);

   localparam int Lanes = Rows + Cols;   // Rows first, then columns

   saPkg::peLinkT laneIn  [Lanes];
   saPkg::peLinkT laneOut [Lanes];

   for (genvar i = 0; i < Rows; i++) begin : gRowLane
      assign laneIn[i] = '{valid: take, last: take && takeLast, value: aCol[i]};
      assign westOut[i] = laneOut[i];
   end

   for (genvar j = 0; j < Cols; j++) begin : gColLane
      assign laneIn[Rows+j] = '{valid: take, last: take && takeLast, value: bRow[j]};
      assign northOut[j] = laneOut[Rows+j];
   end

   for (genvar k = 0; k < Lanes; k++) begin : gLane
      // Accepted beat is registered first, then staggered by its row or column
      localparam int Depth = ((k < Rows) ? k : k - Rows) + 1;

      logic [Depth-1:0] validQ;
      logic [Depth-1:0] lastQ;
      saPkg::operandT   valueQ [Depth];

      always_ff @(posedge clk) begin
         if (reset) begin
            validQ <= '0;
            lastQ  <= '0;
         end else if (advance) begin
            validQ <= (validQ << 1) | Depth'(laneIn[k].valid);
            lastQ  <= (lastQ << 1) | Depth'(laneIn[k].last);
         end
      end

      always_ff @(posedge clk) begin
         if (advance) begin
            valueQ[0] <= laneIn[k].value;
            for (int s = 1; s < Depth; s++) valueQ[s] <= valueQ[s-1];
         end
      end

      assign laneOut[k] = '{valid: validQ[Depth-1], last: lastQ[Depth-1],
                            value: valueQ[Depth-1]};
   end

endmodule

/* design/resultAlign.sv */
`timescale 1ns/1ps

module resultAlign #(
   parameter int Rows = saPkg::DefaultRows,
   parameter int Cols = saPkg::DefaultCols
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            advance,
   input  logic [Rows-1:0][Cols-1:0]       doneValid,
   input  saPkg::accT [Rows-1:0][Cols-1:0] doneSum,
   output logic                            resultValid,
   output saPkg::accT [Rows-1:0][Cols-1:0] result
);

   logic [Rows-1:0][Cols-1:0]       alignedValid;
   saPkg::accT [Rows-1:0][Cols-1:0] alignedSum;

   for (genvar i = 0; i < Rows; i++) begin : gRow
      for (genvar j = 0; j < Cols; j++) begin : gCol
         // Bottom-right element finishes last and needs no delay
         localparam int Depth = (Rows - 1 - i) + (Cols - 1 - j);

         if (Depth == 0) begin : gDirect
            assign alignedValid[i][j] = doneValid[i][j];
            assign alignedSum[i][j]   = doneSum[i][j];
         end else begin : gDelay
            logic [Depth-1:0] validQ;
            saPkg::accT       sumQ [Depth];

            always_ff @(posedge clk) begin
               if (reset) validQ <= '0;
               else if (advance) validQ <= (validQ << 1) | Depth'(doneValid[i][j]);
            end

            always_ff @(posedge clk) begin
               if (advance) begin
                  sumQ[0] <= doneSum[i][j];
                  for (int s = 1; s < Depth; s++) sumQ[s] <= sumQ[s-1];
               end
            end

            assign alignedValid[i][j] = validQ[Depth-1];
            assign alignedSum[i][j]   = sumQ[Depth-1];
         end
      end
   end

   // Output holding register
   always_ff @(posedge clk) begin
      if (reset) resultValid <= 1'b0;
      else if (advance) resultValid <= alignedValid[Rows-1][Cols-1];
   end

   always_ff @(posedge clk) begin
      if (advance && alignedValid[Rows-1][Cols-1]) result <= alignedSum;
   end

   // Every element of a job has to land in the same cycle
   assert property (@(posedge clk) disable iff (reset)
      alignedValid[Rows-1][Cols-1] |-> (&alignedValid));

endmodule

/* design/systolicTop.sv */
`timescale 1ns/1ps

module systolicTop #(
   parameter int Rows = saPkg::DefaultRows,
   parameter int Cols = saPkg::DefaultCols
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            inValid,
   input  logic                            inLast,
   input  saPkg::operandT [Rows-1:0]       aCol,
   input  saPkg::operandT [Cols-1:0]       bRow,
   output logic                            inReady,
   output logic                            resultValid,
   output saPkg::accT [Rows-1:0][Cols-1:0] result,
   input  logic                            resultReady
);

   logic advance;   // Whole pipeline moves or stalls as one
   logic take;
   saPkg::peLinkT [Rows-1:0]        westLink;
   saPkg::peLinkT [Cols-1:0]        northLink;
   logic [Rows-1:0][Cols-1:0]       doneValid;
   saPkg::accT [Rows-1:0][Cols-1:0] doneSum;

   assign advance = !resultValid || resultReady;
   assign inReady = advance;
   assign take    = inValid && inReady;

   operandSkew #(.Rows(Rows), .Cols(Cols)) uSkew (
      .clk, .reset, .advance, .take,
      .takeLast(inLast),
      .aCol, .bRow,
      .westOut (westLink),
      .northOut(northLink)
   );

   peGrid #(.Rows(Rows), .Cols(Cols)) uGrid (
      .clk, .reset, .advance,
      .westIn (westLink),
      .northIn(northLink),
      .doneValid, .doneSum
   );

   resultAlign #(.Rows(Rows), .Cols(Cols)) uAlign (
      .clk, .reset, .advance, .doneValid, .doneSum, .resultValid, .result
   );

   // Held matrix must not change until the consumer takes it
   assert property (@(posedge clk) disable iff (reset)
      (resultValid && !resultReady) |=> (resultValid && $stable(result)));

endmodule

/* dv/tbSystolic.sv */
`timescale 1ns/1ps

module tbSystolic;

   localparam int Rows      = 4;
   localparam int Cols      = 4;
   localparam int Latency   = Rows + Cols;   // Advancing edges from last beat to result
   localparam int ClkPeriod = 20;
   localparam logic [31:0] Seed = 32'hd1543c87;

   localparam int OpRandom = 0;
   localparam int OpCorner = 1;   // Only -128 and 127

   typedef saPkg::accT [Rows-1:0][Cols-1:0] matrixT;

   typedef struct packed {
      int   beats;
      int   opMode;
      logic stall;   // Random back-pressure while this job is sent
   } jobT;

   localparam int NumJobs = 12;

   // Beats, operand mode, back-pressure
   jobT jobTable [NumJobs] = '{
      '{1,   OpRandom, 1'b0},   // Outer product
      '{1,   OpCorner, 1'b0},
      '{500, OpCorner, 1'b0},   // Close to the accumulator limit
      '{300, OpRandom, 1'b0},
      '{1,   OpRandom, 1'b0},
      '{2,   OpRandom, 1'b0},
      '{3,   OpRandom, 1'b0},
      '{1,   OpRandom, 1'b1},
      '{4,   OpRandom, 1'b1},
      '{1,   OpRandom, 1'b1},
      '{7,   OpRandom, 1'b1},
      '{20,  OpRandom, 1'b1}
   };

   logic clk;
   logic reset;
   logic inValid;
   logic inLast;
   saPkg::operandT [Rows-1:0] aCol;
   saPkg::operandT [Cols-1:0] bRow;
   logic inReady;
   logic resultValid;
   matrixT result;
   logic resultReady;

   logic [31:0] opState;
   logic [31:0] stallState;
   logic        stallEnable;
   int          stallLeft;
   matrixT      expQ [$];
   int          lastEdgeQ [$];
   matrixT      held;
   int          advEdge;
   logic        prevAdvance;
   int          jobsArrived;
   int          jobsSeen;

   systolicTop #(.Rows(Rows), .Cols(Cols)) u_dut (
      .clk, .reset, .inValid, .inLast, .aCol, .bRow,
      .inReady, .resultValid, .result, .resultReady
   );

   initial begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] operandBits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int k = 0; k < n; k++) begin
         opState = lfsrNext(opState);
         bits = {bits[30:0], opState[0]};
      end
      return bits;
   endfunction

   function automatic logic [31:0] stallBits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int k = 0; k < n; k++) begin
         stallState = lfsrNext(stallState);
         bits = {bits[30:0], stallState[0]};
      end
      return bits;
   endfunction

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic checkAcc(input saPkg::accT got, input saPkg::accT exp, input int i,
                           input int j);
      if (got !== exp)
         stopRun($sformatf("[FAIL] %0t: result[%0d][%0d] is %0d, expected %0d",
                           $time, i, j, got, exp));
   endtask

   task automatic checkBit(input logic got, input logic exp, input string what);
      if (got !== exp)
         stopRun($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
   endtask

   task automatic checkLatency(input int got, input int exp, input int job);
      if (got != exp)
         stopRun($sformatf("[FAIL] %0t: job %0d result after %0d advancing cycles, expected %0d",
                           $time, job, got, exp));
   endtask

   task automatic sendBeat(input saPkg::operandT [Rows-1:0] a,
                           input saPkg::operandT [Cols-1:0] b, input logic last);
      @(posedge clk);
      inValid <= 1'b1;
      inLast  <= last;
      aCol    <= a;
      bRow    <= b;
      @(negedge clk);
      while (!inReady) @(negedge clk);   // Accepted at the coming edge
   endtask

   task automatic runJob(input jobT job);
      saPkg::operandT [Rows-1:0] a;
      saPkg::operandT [Cols-1:0] b;
      matrixT sum;
      sum = '0;
      stallEnable = job.stall;
      for (int n = 0; n < job.beats; n++) begin
         for (int i = 0; i < Rows; i++) begin
            if (job.opMode == OpCorner)
               a[i] = (i % 2 == 0) ? saPkg::operandT'(-128) : saPkg::operandT'(127);
            else
               a[i] = saPkg::operandT'(operandBits(saPkg::DataWidth));
         end
         for (int j = 0; j < Cols; j++) begin
            if (job.opMode == OpCorner)
               b[j] = (j < Cols / 2) ? saPkg::operandT'(-128) : saPkg::operandT'(127);
            else
               b[j] = saPkg::operandT'(operandBits(saPkg::DataWidth));
         end
         // Element [i][j] sums aCol[i] times bRow[j] over the job
         for (int i = 0; i < Rows; i++)
            for (int j = 0; j < Cols; j++)
               sum[i][j] = sum[i][j] + saPkg::accT'($signed(a[i])) * saPkg::accT'($signed(b[j]));
         sendBeat(a, b, n == job.beats - 1);
      end
      expQ.push_back(sum);
   endtask

   // Consumer holds ready low for random stretches
   always @(posedge clk) begin
      logic [31:0] bits;
      if (reset || !stallEnable) begin
         resultReady <= 1'b1;
         stallLeft = 0;
      end else if (stallLeft > 0) begin
         stallLeft = stallLeft - 1;
      end else begin
         bits = stallBits(4);
         resultReady <= bits[3];
         stallLeft = int'(bits[2:0]);
      end
   end

   always @(negedge clk) begin
      if (reset) begin
         prevAdvance = 1'b0;
      end else begin
         checkBit(inReady, !resultValid || resultReady, "inReady");
         if (resultValid && prevAdvance) begin   // New matrix loaded at the edge just passed
            if (expQ.size() == 0 || lastEdgeQ.size() == 0)
               stopRun("A result appeared with no job outstanding");
            held = expQ.pop_front();
            checkLatency(advEdge - lastEdgeQ.pop_front(), Latency, jobsArrived);
            jobsArrived++;
         end
         if (resultValid) begin
            for (int i = 0; i < Rows; i++)
               for (int j = 0; j < Cols; j++)
                  checkAcc(result[i][j], held[i][j], i, j);
         end
         if (resultValid && resultReady) jobsSeen++;
         if (inReady) begin
            advEdge++;
            if (inValid && inLast) lastEdgeQ.push_back(advEdge);
         end
         prevAdvance = inReady;
      end
   end

   initial begin
      int budget;
      budget = 8 + 50;
      for (int n = 0; n < NumJobs; n++)
         budget += (jobTable[n].beats + Latency) * (jobTable[n].stall ? 16 : 2);
      #(budget * ClkPeriod);
      stopRun("Timeout: the jobs did not all return in time");
   end

   initial begin
      reset       = 1'b1;
      inValid     = 1'b0;
      inLast      = 1'b0;
      aCol        = '0;
      bRow        = '0;
      resultReady = 1'b1;
      stallEnable = 1'b0;
      stallLeft   = 0;
      opState     = Seed;
      stallState  = Seed;
      advEdge     = 0;
      prevAdvance = 1'b0;
      jobsArrived = 0;
      jobsSeen    = 0;
      held        = '0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      checkBit(resultValid, 1'b0, "resultValid after reset");
      checkBit(inReady, 1'b1, "inReady after reset");
      for (int n = 0; n < NumJobs; n++) runJob(jobTable[n]);
      stallEnable = 1'b0;
      @(posedge clk);
      inValid <= 1'b0;
      inLast  <= 1'b0;
      while (jobsSeen < NumJobs) @(negedge clk);
      repeat (Latency + 4) @(negedge clk);   // Room for a duplicate to show up
      if (jobsSeen != NumJobs || jobsArrived != NumJobs || expQ.size() != 0) begin
         stopRun($sformatf("Job count mismatch: %0d taken, %0d arrived, %0d expected",
                           jobsSeen, jobsArrived, NumJobs));
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

/* vlog.f */
common/saPkg.sv
design/boothMultiplier.sv
peArray/processingElement.sv
peArray/peGrid.sv
design/operandSkew.sv
design/resultAlign.sv
design/systolicTop.sv
dv/tbSystolic.sv

/* run.sh */
#!/bin/sh
# Compile and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module tbSystolic -Mdir obj_dir -o simv -f vlog.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi

echo "Pass line not found in $LOG"
exit 1
